// File: conv_out_stage.f
+incdir+design
design/conv_pkg.sv
design/line_buffer.sv
design/align_config.sv
design/conv_align_output.sv
design/conv_out_stage.sv
test/conv_out_stage_assert.sv
test/conv_out_stage_tb.sv

// File: design/align_config.sv
`timescale 1ns/1ns
`include "conv_macros.svh"

module align_config (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           cfg_wr,
	input  logic                           cfg_addr,
	input  conv_pkg::cfg_word_u            cfg_wdata,
	output conv_pkg::cfg_word_u            cfg_rdata,
	output logic                           stage_enable,
	output logic [`CONV_TAP_SEL_WIDTH-1:0] last_tap,
	output logic                           clear_pulse
);

	//////////////////////////////////////////////////
	// Write decode
	//////////////////////////////////////////////////

	logic wr_ctrl;
	logic wr_taps;

	assign wr_ctrl = cfg_wr && (cfg_addr == conv_pkg::CFG_ADDR_CTRL);
	assign wr_taps = cfg_wr && (cfg_addr == conv_pkg::CFG_ADDR_TAPS);

	//////////////////////////////////////////////////
	// CTRL register
	//////////////////////////////////////////////////

	// Enable is held, clear bit only fires the pulse
	always_ff @(posedge clk) begin
		if (reset) begin
			stage_enable <= 1'b0;
		end else if (wr_ctrl) begin
			stage_enable <= cfg_wdata.ctrl.stage_enable;
		end
	end

	// One cycle, the cycle after the write
	always_ff @(posedge clk) begin
		if (reset) begin
			clear_pulse <= 1'b0;
		end else begin
			clear_pulse <= wr_ctrl && cfg_wdata.ctrl.clear;
		end
	end

	//////////////////////////////////////////////////
	// TAPS register
	//////////////////////////////////////////////////

	// Deepest tap is the default
	always_ff @(posedge clk) begin
		if (reset) begin
			last_tap <= `CONV_TAP_SEL_WIDTH'(`CONV_NUM_TAPS - 1);
		end else if (wr_taps) begin
			last_tap <= cfg_wdata.taps.last_tap;
		end
	end

	//////////////////////////////////////////////////
	// Readback
	//////////////////////////////////////////////////

	// Reserved bits and clear read as zero
	always_comb begin
		cfg_rdata = '0;
		case (cfg_addr)
			conv_pkg::CFG_ADDR_CTRL: begin
				cfg_rdata.ctrl.stage_enable = stage_enable;
			end
			conv_pkg::CFG_ADDR_TAPS: begin
				cfg_rdata.taps.last_tap = last_tap;
			end
		endcase
	end

endmodule

// File: design/conv_align_output.sv
`timescale 1ns/1ns
`include "conv_macros.svh"

module conv_align_output (
	input  logic                           clk,
	input  logic                           reset,
	input  conv_pkg::stream_word_t         stream_in,
	input  logic                           stage_enable,
	input  logic [`CONV_TAP_SEL_WIDTH-1:0] last_tap,
	input  logic                           clear_pulse,
	output conv_pkg::stream_word_t         stream_out,
	output logic                           locked
);

	localparam int WORD_W = $bits(conv_pkg::stream_word_t);

	//////////////////////////////////////////////////
	// Tap chain
	//////////////////////////////////////////////////

	// Tap k lags the input by k line depths
	conv_pkg::stream_word_t tap [`CONV_NUM_TAPS];

	assign tap[0] = stream_in;

	genvar k;
	generate
		for (k = 1; k < `CONV_NUM_TAPS; k++) begin : g_line
			line_buffer #(
				.DEPTH(`CONV_LINE_DEPTH),
				.WIDTH(WORD_W)
			) u_line_buffer (
				.clk  (clk),
				.reset(reset),
				.din  (tap[k-1]),
				.dout (tap[k])
			);
		end
	endgenerate

	//////////////////////////////////////////////////
	// Lock
	//////////////////////////////////////////////////

	// Last active tap has seen real data
	logic last_tap_valid;

	assign last_tap_valid = tap[last_tap].valid;

	// Drop on clear or disable, set once the deepest tap fills
	always_ff @(posedge clk) begin
		if (reset) begin
			locked <= 1'b0;
		end else if (clear_pulse || !stage_enable) begin
			locked <= 1'b0;
		end else if (last_tap_valid) begin
			locked <= 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// Deepest valid tap select
	//////////////////////////////////////////////////

	logic                           sel_hit;
	logic [`CONV_TAP_SEL_WIDTH-1:0] sel_idx;

	// Ascending scan, later hits override
	// so the deepest valid tap in range wins
	always_comb begin
		sel_hit = 1'b0;
		sel_idx = '0;
		for (int i = 0; i < `CONV_NUM_TAPS; i++) begin
			if ((i <= int'(last_tap)) && tap[i].valid) begin
				sel_hit = 1'b1;
				sel_idx = `CONV_TAP_SEL_WIDTH'(i);
			end
		end
	end

	//////////////////////////////////////////////////
	// Output register
	//////////////////////////////////////////////////

	logic take;

	assign take = locked && sel_hit;

	// Data holds its last value on idle cycles
	always_ff @(posedge clk) begin
		if (reset) begin
			stream_out.valid <= 1'b0;
		end else begin
			stream_out.valid <= take;
			if (take) begin
				stream_out.data <= tap[sel_idx].data;
			end
		end
	end

endmodule

// File: design/conv_macros.svh
`ifndef CONV_MACROS_SVH
`define CONV_MACROS_SVH

//////////////////////////////////////////////////
// Stream geometry
//////////////////////////////////////////////////

// Width of one convolution result word
`define CONV_DATA_WIDTH 32

// Taps built in the chain
// Tap 0 is the raw input, the rest hang off line buffers
`define CONV_NUM_TAPS 4

// Cycles between neighbouring taps
`define CONV_LINE_DEPTH 6

//////////////////////////////////////////////////
// Tap indexing
//////////////////////////////////////////////////

// Enough bits to name any tap
`define CONV_TAP_SEL_WIDTH 2

`endif

// File: design/conv_out_stage.sv
`timescale 1ns/1ns
`include "conv_macros.svh"

module conv_out_stage (
	input  logic                   clk,
	input  logic                   reset,
	input  conv_pkg::stream_word_t stream_in,
	output conv_pkg::stream_word_t stream_out,
	output logic                   locked,
	input  logic                   cfg_wr,
	input  logic                   cfg_addr,
	input  conv_pkg::cfg_word_u    cfg_wdata,
	output conv_pkg::cfg_word_u    cfg_rdata
);

	//////////////////////////////////////////////////
	// Config to aligner
	//////////////////////////////////////////////////

	logic                           stage_enable;
	logic [`CONV_TAP_SEL_WIDTH-1:0] last_tap;
	logic                           clear_pulse;

	// Register block
	align_config u_align_config (
		.clk         (clk),
		.reset       (reset),
		.cfg_wr      (cfg_wr),
		.cfg_addr    (cfg_addr),
		.cfg_wdata   (cfg_wdata),
		.cfg_rdata   (cfg_rdata),
		.stage_enable(stage_enable),
		.last_tap    (last_tap),
		.clear_pulse (clear_pulse)
	);

	//////////////////////////////////////////////////
	// Stream path
	//////////////////////////////////////////////////

	// Tap chain and output select
	conv_align_output u_conv_align_output (
		.clk         (clk),
		.reset       (reset),
		.stream_in   (stream_in),
		.stage_enable(stage_enable),
		.last_tap    (last_tap),
		.clear_pulse (clear_pulse),
		.stream_out  (stream_out),
		.locked      (locked)
	);

endmodule

// File: design/conv_pkg.sv
`include "conv_macros.svh"

package conv_pkg;

	//////////////////////////////////////////////////
	// Stream word
	//////////////////////////////////////////////////

	// Valid sits in bit 0
	// Line buffer gates that bit on unwritten entries
	typedef struct packed {
		logic [`CONV_DATA_WIDTH-1:0] data;
		logic                        valid;
	} stream_word_t;

	//////////////////////////////////////////////////
	// Configuration word
	//////////////////////////////////////////////////

	// CTRL register layout
	typedef struct packed {
		logic [13:0] reserved;
		logic        clear;
		logic        stage_enable;
	} cfg_ctrl_t;

	// TAPS register layout
	typedef struct packed {
		logic [16-`CONV_TAP_SEL_WIDTH-1:0] reserved;
		logic [`CONV_TAP_SEL_WIDTH-1:0]    last_tap;
	} cfg_taps_t;

	// Same 16-bit write word, meaning picked by address
	typedef union packed {
		cfg_ctrl_t ctrl;
		cfg_taps_t taps;
	} cfg_word_u;

	// Register map
	localparam logic CFG_ADDR_CTRL = 1'b0;
	localparam logic CFG_ADDR_TAPS = 1'b1;

endpackage

// File: design/line_buffer.sv
`timescale 1ns/1ns

module line_buffer #(
	parameter int DEPTH = 6,
	parameter int WIDTH = 33
) (
	input  logic             clk,
	input  logic             reset,
	input  logic [WIDTH-1:0] din,
	output logic [WIDTH-1:0] dout
);

	// Pointer needs at least one bit even for DEPTH 1
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	//////////////////////////////////////////////////
	// Storage
	//////////////////////////////////////////////////

	logic [WIDTH-1:0] mem [DEPTH];

	// Slot written since reset
	logic [DEPTH-1:0] filled;

	// Current slot, oldest on read and newest on write
	logic [PTR_W-1:0] ptr;
	logic [PTR_W-1:0] ptr_next;

	logic [WIDTH-1:0] oldest;

	//////////////////////////////////////////////////
	// Pointer
	//////////////////////////////////////////////////

	// Wrap at the last slot
	always_comb begin
		if (ptr == PTR_W'(DEPTH - 1)) begin
			ptr_next = '0;
		end else begin
			ptr_next = ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ptr <= '0;
		end else begin
			ptr <= ptr_next;
		end
	end

	//////////////////////////////////////////////////
	// Memory write
	//////////////////////////////////////////////////

	// Written every cycle, no stall
	always_ff @(posedge clk) begin
		mem[ptr] <= din;
	end

	// Fill flags
	always_ff @(posedge clk) begin
		if (reset) begin
			filled <= '0;
		end else begin
			filled[ptr] <= 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// Read side
	//////////////////////////////////////////////////

	// Slot written DEPTH cycles ago
	assign oldest = mem[ptr];

	// Stale content never reads as valid
	// Upper bits pass as they are
	always_comb begin
		dout    = oldest;
		dout[0] = oldest[0] & filled[ptr];
	end

endmodule

// File: run.sh
#!/bin/sh
# Compile with Verilator, run, then look for the pass line in the output

verilator --binary --timing --assert \
	--top-module conv_out_stage_tb \
	-f conv_out_stage.f \
	-o conv_out_stage_sim \
	&& ./obj_dir/conv_out_stage_sim | tee /dev/stderr | grep -q "Result: PASSED" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

// File: test/conv_out_stage_assert.sv
`timescale 1ns/1ns

module conv_out_stage_assert (
	input logic                   clk,
	input logic                   reset,
	input conv_pkg::stream_word_t stream_out,
	input logic                   locked,
	input logic                   clear_pulse
);

	//////////////////////////////////////////////////
	// Lock and output
	//////////////////////////////////////////////////

	// Registered output word needs lock one cycle before
	a_valid_needs_lock: assert property (@(posedge clk) disable iff (reset)
		stream_out.valid |-> $past(locked))
	else $error("stream_out.valid seen without locked in the previous cycle");

	//////////////////////////////////////////////////
	// Clear pulse
	//////////////////////////////////////////////////

	// Clear drops the lock on the next edge
	a_clear_drops_lock: assert property (@(posedge clk) disable iff (reset)
		clear_pulse |=> !locked)
	else $error("locked still high in the cycle after clear_pulse");

	// Strictly a single-cycle pulse
	a_clear_one_cycle: assert property (@(posedge clk) disable iff (reset)
		clear_pulse |=> !clear_pulse)
	else $error("clear_pulse high for two cycles in a row");

endmodule

// File: test/conv_out_stage_tb.sv
`timescale 1ns/1ns
`include "conv_macros.svh"

module conv_out_stage_tb;

	localparam int D = `CONV_LINE_DEPTH;

	logic                   clk = 1'b0;
	logic                   reset = 1'b1;
	conv_pkg::stream_word_t stream_in = '0;
	conv_pkg::stream_word_t stream_out;
	logic                   locked;
	logic                   cfg_wr = 1'b0;
	logic                   cfg_addr = 1'b0;
	conv_pkg::cfg_word_u    cfg_wdata = '0;
	conv_pkg::cfg_word_u    cfg_rdata;

	// Input words seen on each edge since reset
	conv_pkg::stream_word_t hist [$];

	// Model state, advanced on each rising edge
	logic                           m_enable = 1'b0;
	logic [`CONV_TAP_SEL_WIDTH-1:0] m_last_tap = `CONV_TAP_SEL_WIDTH'(`CONV_NUM_TAPS - 1);
	logic                           m_clear = 1'b0;
	logic                           m_locked = 1'b0;
	logic                           m_data_set = 1'b0;
	conv_pkg::stream_word_t         exp_out = '0;

	int    value_errors = 0;
	int    check_errors = 0;
	int    timeouts = 0;
	int    out_count = 0;
	string test_name = "reset_state";

	// Stimulus control
	logic stream_random = 1'b0;
	logic arm_first = 1'b0;
	int   first_idx = 0;
	int   base = 0;

	conv_out_stage DUT (
		.clk       (clk),
		.reset     (reset),
		.stream_in (stream_in),
		.stream_out(stream_out),
		.locked    (locked),
		.cfg_wr    (cfg_wr),
		.cfg_addr  (cfg_addr),
		.cfg_wdata (cfg_wdata),
		.cfg_rdata (cfg_rdata)
	);

	bind conv_align_output conv_out_stage_assert u_align_assert (
		.clk        (clk),
		.reset      (reset),
		.stream_out (stream_out),
		.locked     (locked),
		.clear_pulse(clear_pulse)
	);

	always #5 clk = ~clk;

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	// Tap k on edge idx is the input k line depths back
	function automatic conv_pkg::stream_word_t tap_word(input int idx, input int k);
		int src;
		src = idx - k * D;
		if (src < 0) begin
			return '0;
		end
		return hist[src];
	endfunction

	// Deepest valid tap within range, data held when none
	function automatic conv_pkg::stream_word_t expected_out(input int idx, input int lt,
			input logic lk, input conv_pkg::stream_word_t prev);
		conv_pkg::stream_word_t res;
		conv_pkg::stream_word_t cand;
		res = prev;
		res.valid = 1'b0;
		if (lk) begin
			for (int k = lt; k >= 0; k--) begin
				cand = tap_word(idx, k);
				if (cand.valid) begin
					res = cand;
					break;
				end
			end
		end
		return res;
	endfunction

	function automatic conv_pkg::cfg_word_u make_ctrl(input logic enable, input logic clear);
		conv_pkg::cfg_word_u w;
		w = '0;
		w.ctrl.stage_enable = enable;
		w.ctrl.clear = clear;
		return w;
	endfunction

	function automatic conv_pkg::cfg_word_u make_taps(input int lt);
		conv_pkg::cfg_word_u w;
		w = '0;
		w.taps.last_tap = `CONV_TAP_SEL_WIDTH'(lt);
		return w;
	endfunction

	//////////////////////////////////////////////////
	// Compare on every rising edge
	//////////////////////////////////////////////////

	always @(posedge clk) begin : compare_outputs
		conv_pkg::stream_word_t nxt_out;
		logic                   tap_hit;
		int                     idx;
		if (reset) begin
			hist.delete();
			m_enable = 1'b0;
			m_last_tap = `CONV_TAP_SEL_WIDTH'(`CONV_NUM_TAPS - 1);
			m_clear = 1'b0;
			m_locked = 1'b0;
			m_data_set = 1'b0;
			exp_out = '0;
		end else begin
			idx = hist.size();
			assert (locked === m_locked) else begin
				$display("CHECK FAILED %s: locked expected %0b, actual %0b",
					test_name, m_locked, locked);
				value_errors++;
			end
			assert (stream_out.valid === exp_out.valid) else begin
				$display("CHECK FAILED %s: valid expected %0b, actual %0b",
					test_name, exp_out.valid, stream_out.valid);
				value_errors++;
			end
			// Data is defined from the first word out, then held on idle cycles
			if (m_data_set) begin
				assert (stream_out.data === exp_out.data) else begin
					$display("CHECK FAILED %s: data expected %h, actual %h",
						test_name, exp_out.data, stream_out.data);
					value_errors++;
				end
			end
			if (stream_out.valid) begin
				out_count++;
			end
			// Advance the model with this edge's inputs
			hist.push_back(stream_in);
			tap_hit = tap_word(idx, int'(m_last_tap)).valid;
			nxt_out = expected_out(idx, int'(m_last_tap), m_locked, exp_out);
			if (m_clear || !m_enable) begin
				m_locked = 1'b0;
			end else if (tap_hit) begin
				m_locked = 1'b1;
			end
			m_clear = cfg_wr && (cfg_addr == conv_pkg::CFG_ADDR_CTRL) && cfg_wdata.ctrl.clear;
			if (cfg_wr && (cfg_addr == conv_pkg::CFG_ADDR_CTRL)) begin
				m_enable = cfg_wdata.ctrl.stage_enable;
			end
			if (cfg_wr && (cfg_addr == conv_pkg::CFG_ADDR_TAPS)) begin
				m_last_tap = cfg_wdata.taps.last_tap;
			end
			if (nxt_out.valid) begin
				m_data_set = 1'b1;
			end
			exp_out = nxt_out;
		end
	end

	//////////////////////////////////////////////////
	// Stimulus tasks
	//////////////////////////////////////////////////

	// One falling edge, new stream word, write strobe dropped
	task automatic next_cycle();
		@(negedge clk);
		cfg_wr = 1'b0;
		if (stream_random) begin
			stream_in.valid = ($urandom_range(0, 3) != 0);
			stream_in.data = $urandom;
		end else begin
			stream_in = '0;
		end
		// Index of the edge that takes this word
		if (arm_first && stream_in.valid) begin
			first_idx = hist.size();
			arm_first = 1'b0;
		end
	endtask

	task automatic write_cfg(input logic addr, input conv_pkg::cfg_word_u word);
		next_cycle();
		cfg_wr = 1'b1;
		cfg_addr = addr;
		cfg_wdata = word;
	endtask

	task automatic check_readback(input logic addr, input conv_pkg::cfg_word_u exp_word);
		next_cycle();
		cfg_addr = addr;
		#1;
		assert (cfg_rdata === exp_word) else begin
			$display("CHECK FAILED %s: readback at %0b expected %h, actual %h",
				test_name, addr, exp_word, cfg_rdata);
			check_errors++;
		end
	endtask

	task automatic wait_locked(input logic level, input int limit);
		logic done;
		done = 1'b0;
		for (int n = 0; n < limit && !done; n++) begin
			next_cycle();
			if (locked === level) begin
				done = 1'b1;
			end
		end
		if (!done) begin
			$display("Timeout in %s: locked did not reach %0b within %0d cycles",
				test_name, level, limit);
			timeouts++;
		end
	endtask

	// Start from empty taps, lock must follow k line depths plus one
	task automatic check_lock_latency(input int k);
		int expected;
		int lock_idx;
		expected = k * D + 1;
		arm_first = 1'b1;
		stream_random = 1'b1;
		wait_locked(1'b1, 100);
		// Edges taken so far when lock is first seen
		lock_idx = hist.size();
		assert (!arm_first && (lock_idx - first_idx == expected)) else begin
			$display("CHECK FAILED %s: lock latency expected %0d, actual %0d",
				test_name, expected, lock_idx - first_idx);
			check_errors++;
		end
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial begin
		void'($urandom(52982));
		repeat (8) @(negedge clk);
		reset = 1'b0;

		// Reset values
		assert (locked === 1'b0) else begin
			$display("CHECK FAILED %s: locked expected 0, actual %0b", test_name, locked);
			check_errors++;
		end
		assert (stream_out.valid === 1'b0) else begin
			$display("CHECK FAILED %s: valid expected 0, actual %0b",
				test_name, stream_out.valid);
			check_errors++;
		end
		check_readback(conv_pkg::CFG_ADDR_CTRL, make_ctrl(1'b0, 1'b0));
		check_readback(conv_pkg::CFG_ADDR_TAPS, make_taps(`CONV_NUM_TAPS - 1));

		// Stage disabled, stream flowing
		test_name = "disabled";
		stream_random = 1'b1;
		base = out_count;
		repeat (40) next_cycle();
		assert (out_count == base) else begin
			$display("Output words appeared while the stage was disabled");
			check_errors++;
		end

		// Flush the chain, enable, time the lock
		test_name = "lock_latency";
		stream_random = 1'b0;
		repeat (30) next_cycle();
		write_cfg(conv_pkg::CFG_ADDR_CTRL, make_ctrl(1'b1, 1'b0));
		check_lock_latency(`CONV_NUM_TAPS - 1);

		// Locked tracking with random gaps
		test_name = "tracking";
		base = out_count;
		repeat (150) next_cycle();
		assert (out_count > base) else begin
			$display("No valid output words while locked with input flowing");
			check_errors++;
		end

		// Shorter chain through TAPS, then clear
		test_name = "tap1";
		stream_random = 1'b0;
		repeat (30) next_cycle();
		write_cfg(conv_pkg::CFG_ADDR_TAPS, make_taps(1));
		write_cfg(conv_pkg::CFG_ADDR_CTRL, make_ctrl(1'b1, 1'b1));
		wait_locked(1'b0, 5);
		check_readback(conv_pkg::CFG_ADDR_TAPS, make_taps(1));
		check_lock_latency(1);
		repeat (100) next_cycle();

		// Clear while streaming
		test_name = "clear";
		write_cfg(conv_pkg::CFG_ADDR_CTRL, make_ctrl(1'b1, 1'b1));
		wait_locked(1'b0, 5);
		check_readback(conv_pkg::CFG_ADDR_CTRL, make_ctrl(1'b1, 1'b0));
		wait_locked(1'b1, 60);
		repeat (60) next_cycle();

		stream_random = 1'b0;
		repeat (5) next_cycle();
		$display("Errors: %0d value, %0d check, %0d timeout",
			value_errors, check_errors, timeouts);
		if (value_errors == 0 && check_errors == 0 && timeouts == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule
